/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_kernel
FILELIST  = list.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(BUILD_DIR)

/* include/host_bridge_params.svh */
`ifndef HOST_BRIDGE_PARAMS_SVH
`define HOST_BRIDGE_PARAMS_SVH

// bus widths
`define HB_HOST_ADDR_W 15
`define HB_HOST_DATA_W 32
`define HB_AXI_ADDR_W 64
`define HB_AXI_DATA_W 128
`define HB_AXI_ID_W 4

`define HB_STAGE_WORDS 8      // 32-bit words in the staging register
`define HB_FIFO_LOG2_DEPTH 9  // 512 entries per queue

// fixed outgoing write fields
`define HB_AXI_ID 1
`define HB_BURST_INCR 1

// host register map
`define HB_REG_STAGE0 'h00
`define HB_REG_AW_PUSH 'h20
`define HB_REG_W_PUSH 'h30
`define HB_REG_B_STATUS 'h50
`define HB_REG_B_POP 'h54
`define HB_REG_LINK_RST_ON 'hc0
`define HB_REG_LINK_RST_OFF 'hc4

`endif

/* list.f */
+incdir+include
rtl/host_bridge_pkg.sv
rtl/sync_fifo.sv
rtl/host_regs.sv
rtl/axi_write_master.sv
rtl/kernel_top.sv
tb/tb_kernel.sv

/* rtl/axi_write_master.sv */
`default_nettype none

`include "host_bridge_params.svh"

module axi_write_master (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       aw_push,
  input  host_bridge_pkg::aw_req_t   aw_req,
  input  logic                       w_push,
  input  host_bridge_pkg::w_beat_t   w_beat,
  output logic                       b_valid,
  output host_bridge_pkg::b_rsp_t    b_head,
  input  logic                       b_pop,
  // AW
  output host_bridge_pkg::axi_addr_t awaddr,
  output host_bridge_pkg::axi_size_t awsize,
  output logic [1:0]                 awburst,
  output logic [7:0]                 awlen,
  output host_bridge_pkg::axi_id_t   awid,
  output logic [3:0]                 awcache,
  output logic [0:0]                 awlock,
  output logic [2:0]                 awprot,
  output logic [3:0]                 awqos,
  output logic                       awvalid,
  input  logic                       awready,
  // W
  output host_bridge_pkg::axi_data_t wdata,
  output host_bridge_pkg::axi_strb_t wstrb,
  output logic                       wlast,
  output logic                       wvalid,
  input  logic                       wready,
  // B
  input  host_bridge_pkg::axi_id_t   bid,
  input  host_bridge_pkg::axi_resp_t bresp,
  input  logic                       bvalid,
  output logic                       bready
);

  host_bridge_pkg::aw_req_t aw_head;
  host_bridge_pkg::w_beat_t w_head;
  host_bridge_pkg::b_rsp_t  b_in;

  sync_fifo #(
    .DATA_WIDTH($bits(host_bridge_pkg::aw_req_t)),
    .LOG2_DEPTH(`HB_FIFO_LOG2_DEPTH)
  ) u_aw_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (aw_push),
    .wdata  (aw_req),
    .wready (),         // overflow drops the push
    .rvalid (awvalid),
    .rdata  (aw_head),
    .rready (awready)
  );

  sync_fifo #(
    .DATA_WIDTH($bits(host_bridge_pkg::w_beat_t)),
    .LOG2_DEPTH(`HB_FIFO_LOG2_DEPTH)
  ) u_w_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (w_push),
    .wdata  (w_beat),
    .wready (),
    .rvalid (wvalid),
    .rdata  (w_head),
    .rready (wready)
  );

  assign b_in = '{id: bid, resp: bresp};

  sync_fifo #(
    .DATA_WIDTH($bits(host_bridge_pkg::b_rsp_t)),
    .LOG2_DEPTH(`HB_FIFO_LOG2_DEPTH)
  ) u_b_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (bvalid),
    .wdata  (b_in),
    .wready (bready),   // accept while there is room
    .rvalid (b_valid),
    .rdata  (b_head),
    .rready (b_pop)
  );

  // single-beat INCR writes
  assign awaddr  = aw_head.addr;
  assign awsize  = aw_head.size;
  assign awburst = 2'(`HB_BURST_INCR);
  assign awlen   = 8'd0;  // one beat
  assign awid    = host_bridge_pkg::axi_id_t'(`HB_AXI_ID);
  assign awcache = 4'd0;
  assign awlock  = 1'b0;
  assign awprot  = 3'd0;
  assign awqos   = 4'd0;

  assign wdata = w_head.data;
  assign wstrb = w_head.strb;
  assign wlast = 1'b1;

endmodule

`default_nettype wire

/* rtl/host_bridge_pkg.sv */
`default_nettype none

`include "host_bridge_params.svh"

package host_bridge_pkg;

  typedef logic [`HB_HOST_ADDR_W-1:0] host_addr_t;
  typedef logic [`HB_HOST_DATA_W-1:0] host_word_t;

  typedef logic [`HB_AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [`HB_AXI_DATA_W-1:0] axi_data_t;
  typedef logic [`HB_AXI_DATA_W/8-1:0] axi_strb_t;
  typedef logic [`HB_AXI_ID_W-1:0] axi_id_t;
  typedef logic [1:0] axi_resp_t;
  typedef logic [2:0] axi_size_t;

  typedef logic [`HB_STAGE_WORDS*`HB_HOST_DATA_W-1:0] stage_t;

  // both sit in the low bits of the staging register
  typedef struct packed {
    axi_size_t size;
    axi_addr_t addr;
  } aw_req_t;

  typedef struct packed {
    axi_strb_t strb;
    axi_data_t data;
  } w_beat_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_rsp_t;

endpackage

`default_nettype wire

/* rtl/host_regs.sv */
`default_nettype none

`include "host_bridge_params.svh"

module host_regs (
  input  logic                        clk,
  input  logic                        rstn,
  // host port
  input  logic                        host_en,
  input  logic [3:0]                  host_we,
  input  host_bridge_pkg::host_addr_t host_addr,
  input  host_bridge_pkg::host_word_t host_din,
  output host_bridge_pkg::host_word_t host_dout,
  // towards the write master
  output logic                        aw_push,
  output host_bridge_pkg::aw_req_t    aw_req,
  output logic                        w_push,
  output host_bridge_pkg::w_beat_t    w_beat,
  input  logic                        b_valid,
  input  host_bridge_pkg::b_rsp_t     b_head,
  output logic                        b_pop,
  // link reset
  output logic                        ocu_rstn
);

  localparam int IDX_W = $clog2(`HB_STAGE_WORDS);
  localparam int WORD_W = `HB_HOST_DATA_W;

  host_bridge_pkg::stage_t     stage;
  host_bridge_pkg::host_addr_t stage_off;
  logic [IDX_W-1:0]            stage_idx;
  logic                        stage_hit;
  logic                        wr_en;
  logic                        link_up;

  assign wr_en = host_en && (host_we != '0);  // any other cycle is a read

  // offset wraps below the base, so one compare covers the window
  assign stage_off = host_addr - host_bridge_pkg::host_addr_t'(`HB_REG_STAGE0);
  assign stage_hit = (stage_off < host_bridge_pkg::host_addr_t'(`HB_STAGE_WORDS * 4)) &&
                     (stage_off[1:0] == 2'b00);
  assign stage_idx = stage_off[IDX_W+1:2];

  // strobes and link reset
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_push  <= 1'b0;
      w_push   <= 1'b0;
      b_pop    <= 1'b0;
      link_up  <= 1'b1;
      ocu_rstn <= 1'b0;  // held low one cycle past reset
    end else begin
      aw_push  <= 1'b0;
      w_push   <= 1'b0;
      b_pop    <= 1'b0;
      ocu_rstn <= link_up;
      if (wr_en) begin
        case (host_addr)
          host_bridge_pkg::host_addr_t'(`HB_REG_AW_PUSH):      aw_push <= 1'b1;
          host_bridge_pkg::host_addr_t'(`HB_REG_W_PUSH):       w_push  <= 1'b1;
          host_bridge_pkg::host_addr_t'(`HB_REG_B_POP):        b_pop   <= b_valid;
          host_bridge_pkg::host_addr_t'(`HB_REG_LINK_RST_ON):  link_up <= 1'b0;
          host_bridge_pkg::host_addr_t'(`HB_REG_LINK_RST_OFF): link_up <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // staging register, queue payloads and readback
  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (stage_hit) begin
        stage[stage_idx*WORD_W +: WORD_W] <= host_din;
      end
      if (host_addr == host_bridge_pkg::host_addr_t'(`HB_REG_AW_PUSH)) begin
        aw_req <= host_bridge_pkg::aw_req_t'(stage[$bits(host_bridge_pkg::aw_req_t)-1:0]);
      end
      if (host_addr == host_bridge_pkg::host_addr_t'(`HB_REG_W_PUSH)) begin
        w_beat <= host_bridge_pkg::w_beat_t'(stage[$bits(host_bridge_pkg::w_beat_t)-1:0]);
      end
      if (host_addr == host_bridge_pkg::host_addr_t'(`HB_REG_B_POP)) begin
        stage <= host_bridge_pkg::stage_t'(b_head);  // zero-extended response
      end
    end else begin
      if (stage_hit) begin
        host_dout <= stage[stage_idx*WORD_W +: WORD_W];
      end else if (host_addr == host_bridge_pkg::host_addr_t'(`HB_REG_B_STATUS)) begin
        host_dout <= host_bridge_pkg::host_word_t'(b_valid);
      end
      // unmapped reads keep the last value
    end
  end

endmodule

`default_nettype wire

/* rtl/kernel_top.sv */
`default_nettype none

module kernel_top (
  input  logic                       clk,
  input  logic                       rstn,
  output logic                       ocu_rstn,
  // host port
  input  logic                       host_en,
  input  logic [3:0]                 host_we,
  input  host_bridge_pkg::host_addr_t host_addr,
  input  host_bridge_pkg::host_word_t host_din,
  output host_bridge_pkg::host_word_t host_dout,
  // AW
  output host_bridge_pkg::axi_addr_t awaddr,
  output host_bridge_pkg::axi_size_t awsize,
  output logic [1:0]                 awburst,
  output logic [7:0]                 awlen,
  output host_bridge_pkg::axi_id_t   awid,
  output logic [3:0]                 awcache,
  output logic [0:0]                 awlock,
  output logic [2:0]                 awprot,
  output logic [3:0]                 awqos,
  output logic                       awvalid,
  input  logic                       awready,
  // W
  output host_bridge_pkg::axi_data_t wdata,
  output host_bridge_pkg::axi_strb_t wstrb,
  output logic                       wlast,
  output logic                       wvalid,
  input  logic                       wready,
  // B
  input  host_bridge_pkg::axi_id_t   bid,
  input  host_bridge_pkg::axi_resp_t bresp,
  input  logic                       bvalid,
  output logic                       bready
);

  logic                     aw_push;
  host_bridge_pkg::aw_req_t aw_req;
  logic                     w_push;
  host_bridge_pkg::w_beat_t w_beat;
  logic                     b_valid;
  host_bridge_pkg::b_rsp_t  b_head;
  logic                     b_pop;

  host_regs u_regs (
    .clk       (clk),
    .rstn      (rstn),
    .host_en   (host_en),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_din  (host_din),
    .host_dout (host_dout),
    .aw_push   (aw_push),
    .aw_req    (aw_req),
    .w_push    (w_push),
    .w_beat    (w_beat),
    .b_valid   (b_valid),
    .b_head    (b_head),
    .b_pop     (b_pop),
    .ocu_rstn  (ocu_rstn)
  );

  axi_write_master u_wr_master (
    .clk     (clk),
    .rstn    (rstn),
    .aw_push (aw_push),
    .aw_req  (aw_req),
    .w_push  (w_push),
    .w_beat  (w_beat),
    .b_valid (b_valid),
    .b_head  (b_head),
    .b_pop   (b_pop),
    .awaddr  (awaddr),
    .awsize  (awsize),
    .awburst (awburst),
    .awlen   (awlen),
    .awid    (awid),
    .awcache (awcache),
    .awlock  (awlock),
    .awprot  (awprot),
    .awqos   (awqos),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .wvalid  (wvalid),
    .wready  (wready),
    .bid     (bid),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready)
  );

endmodule

`default_nettype wire

/* rtl/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
  parameter int DATA_WIDTH = 8,
  parameter int LOG2_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  wvalid,
  input  logic [DATA_WIDTH-1:0] wdata,
  output logic                  wready,
  output logic                  rvalid,
  output logic [DATA_WIDTH-1:0] rdata,
  input  logic                  rready
);

  localparam int DEPTH = 2 ** LOG2_DEPTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [LOG2_DEPTH-1:0] wptr;
  logic [LOG2_DEPTH-1:0] rptr;
  logic [LOG2_DEPTH:0]   count;
  logic                  do_wr;
  logic                  do_rd;

  assign wready = (count != (LOG2_DEPTH+1)'(DEPTH));
  assign rvalid = (count != '0);
  assign rdata  = mem[rptr];  // head shown without a read cycle

  assign do_wr = wvalid && wready;
  assign do_rd = rvalid && rready;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (do_wr) begin
        wptr <= wptr + 1'b1;  // wraps at depth
      end
      if (do_rd) begin
        rptr <= rptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* tb/tb_kernel.sv */
`default_nettype none

`include "host_bridge_params.svh"

module tb_kernel;

  localparam int MAX_VEC = 64;
  localparam host_bridge_pkg::host_word_t OP_WRITE = 32'h0;
  localparam host_bridge_pkg::host_word_t OP_READ  = 32'h1;
  localparam host_bridge_pkg::host_word_t OP_B     = 32'h2;
  localparam host_bridge_pkg::host_word_t OP_BEAT  = 32'h3;
  localparam host_bridge_pkg::host_word_t OP_RAND  = 32'h4;
  localparam host_bridge_pkg::host_word_t OP_LINK  = 32'h5;
  localparam host_bridge_pkg::host_word_t OP_END   = 32'hf;

  logic                        clk;
  logic                        rstn;
  logic                        ocu_rstn;
  logic                        host_en;
  logic [3:0]                  host_we;
  host_bridge_pkg::host_addr_t host_addr;
  host_bridge_pkg::host_word_t host_din;
  host_bridge_pkg::host_word_t host_dout;
  host_bridge_pkg::axi_addr_t  awaddr;
  host_bridge_pkg::axi_size_t  awsize;
  logic [1:0]                  awburst;
  logic [7:0]                  awlen;
  host_bridge_pkg::axi_id_t    awid;
  logic [3:0]                  awcache;
  logic [0:0]                  awlock;
  logic [2:0]                  awprot;
  logic [3:0]                  awqos;
  logic                        awvalid;
  logic                        awready;
  host_bridge_pkg::axi_data_t  wdata;
  host_bridge_pkg::axi_strb_t  wstrb;
  logic                        wlast;
  logic                        wvalid;
  logic                        wready;
  host_bridge_pkg::axi_id_t    bid;
  host_bridge_pkg::axi_resp_t  bresp;
  logic                        bvalid;
  logic                        bready;

  host_bridge_pkg::host_word_t vec_mem [4*MAX_VEC];
  int                          num_vec;
  int                          errors;
  int                          checks;
  logic                        random_ready;
  host_bridge_pkg::host_word_t stage_model [`HB_STAGE_WORDS];
  host_bridge_pkg::aw_req_t    aw_exp_q [$];
  host_bridge_pkg::aw_req_t    aw_got_q [$];
  host_bridge_pkg::w_beat_t    w_exp_q [$];
  host_bridge_pkg::w_beat_t    w_got_q [$];
  host_bridge_pkg::b_rsp_t     b_model_q [$];
  logic                        aw_hold;
  logic                        w_hold;
  host_bridge_pkg::aw_req_t    aw_prev;
  host_bridge_pkg::w_beat_t    w_prev;

  kernel_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check(input logic [127:0] actual, input logic [127:0] expected,
                       input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
    end
  endtask

  // what the staging register and the queues should hold after a host write
  task automatic update_model(input host_bridge_pkg::host_addr_t addr,
                              input host_bridge_pkg::host_word_t data);
    host_bridge_pkg::aw_req_t aw_new;
    host_bridge_pkg::w_beat_t w_new;
    if (addr < host_bridge_pkg::host_addr_t'(`HB_STAGE_WORDS * 4) && addr[1:0] == 2'b00) begin
      stage_model[addr[4:2]] = data;
    end else if (addr == host_bridge_pkg::host_addr_t'(`HB_REG_AW_PUSH)) begin
      aw_new = {stage_model[2][2:0], stage_model[1], stage_model[0]};
      aw_exp_q.push_back(aw_new);
    end else if (addr == host_bridge_pkg::host_addr_t'(`HB_REG_W_PUSH)) begin
      w_new = {stage_model[4][15:0], stage_model[3], stage_model[2],
               stage_model[1], stage_model[0]};
      w_exp_q.push_back(w_new);
    end else if (addr == host_bridge_pkg::host_addr_t'(`HB_REG_B_POP) &&
                 b_model_q.size() != 0) begin
      foreach (stage_model[i]) stage_model[i] = '0;
      stage_model[0] = {26'd0, b_model_q.pop_front()};
    end
  endtask

  task automatic host_write(input host_bridge_pkg::host_addr_t addr,
                            input host_bridge_pkg::host_word_t data);
    @(posedge clk);
    host_en   <= 1'b1;
    host_we   <= 4'hf;
    host_addr <= addr;
    host_din  <= data;
    @(posedge clk);
    host_en <= 1'b0;
    host_we <= 4'h0;
    update_model(addr, data);
  endtask

  task automatic host_read(input host_bridge_pkg::host_addr_t addr,
                           output host_bridge_pkg::host_word_t data);
    @(posedge clk);
    host_en   <= 1'b1;
    host_we   <= 4'h0;
    host_addr <= addr;
    @(posedge clk);
    host_en <= 1'b0;
    @(posedge clk);
    data = host_dout;  // registered one cycle after the address
  endtask

  task automatic b_inject(input host_bridge_pkg::host_word_t data);
    host_bridge_pkg::b_rsp_t b_new;
    b_new = data[5:0];
    @(posedge clk);
    bvalid <= 1'b1;
    bid    <= data[5:2];
    bresp  <= data[1:0];
    do begin
      @(posedge clk);
    end while (!bready);
    bvalid <= 1'b0;
    b_model_q.push_back(b_new);
  endtask

  // next AW or W handshake against the model, low word also against the vector
  task automatic expect_beat(input host_bridge_pkg::host_addr_t addr,
                             input host_bridge_pkg::host_word_t low_word);
    host_bridge_pkg::aw_req_t got_aw;
    host_bridge_pkg::aw_req_t exp_aw;
    host_bridge_pkg::w_beat_t got_w;
    host_bridge_pkg::w_beat_t exp_w;
    if (addr == host_bridge_pkg::host_addr_t'(`HB_REG_AW_PUSH)) begin
      while (aw_got_q.size() == 0) @(posedge clk);
      got_aw = aw_got_q.pop_front();
      if (aw_exp_q.size() == 0) begin
        errors++;
        $display("an AW handshake came out with no push pending");
      end else begin
        exp_aw = aw_exp_q.pop_front();
        check(128'(got_aw.addr), 128'(exp_aw.addr), "awaddr");
        check(128'(got_aw.size), 128'(exp_aw.size), "awsize");
      end
      check(128'(got_aw.addr[31:0]), 128'(low_word), "awaddr low word");
    end else begin
      while (w_got_q.size() == 0) @(posedge clk);
      got_w = w_got_q.pop_front();
      if (w_exp_q.size() == 0) begin
        errors++;
        $display("a W handshake came out with no push pending");
      end else begin
        exp_w = w_exp_q.pop_front();
        check(128'(got_w.data), 128'(exp_w.data), "wdata");
        check(128'(got_w.strb), 128'(exp_w.strb), "wstrb");
      end
      check(128'(got_w.data[31:0]), 128'(low_word), "wdata low word");
    end
  endtask

  // AXI slave side
  always @(posedge clk) begin
    host_bridge_pkg::aw_req_t aw_now;
    host_bridge_pkg::w_beat_t w_now;
    aw_now = {awsize, awaddr};
    w_now  = {wstrb, wdata};
    if (rstn) begin
      if (aw_hold) begin
        check(128'(awvalid), 128'(1), "awvalid dropped while stalled");
        check(128'(aw_now), 128'(aw_prev), "AW fields moved while stalled");
      end
      if (w_hold) begin
        check(128'(wvalid), 128'(1), "wvalid dropped while stalled");
        check(128'(wdata), 128'(w_prev.data), "wdata moved while stalled");
        check(128'(wstrb), 128'(w_prev.strb), "wstrb moved while stalled");
      end
      if (awvalid && awready) begin
        aw_got_q.push_back(aw_now);
        check(128'(awburst), 128'(1), "awburst");
        check(128'(awlen), 128'(0), "awlen");
        check(128'(awid), 128'(1), "awid");
        check(128'({awcache, awlock, awprot, awqos}), 128'(0), "cache/lock/prot/qos");
      end
      if (wvalid && wready) begin
        w_got_q.push_back(w_now);
        check(128'(wlast), 128'(1), "wlast");
      end
      aw_hold = awvalid && !awready;
      w_hold  = wvalid && !wready;
      aw_prev = aw_now;
      w_prev  = w_now;
      awready <= random_ready ? 1'($urandom) : 1'b1;
      wready  <= random_ready ? 1'($urandom) : 1'b1;
    end
  end

  initial begin
    wait (num_vec > 0);
    #((num_vec + 200) * 100);
    $display("timeout: the run did not end within %0d clock cycles", num_vec + 200);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int n;
    host_bridge_pkg::host_word_t op;
    host_bridge_pkg::host_word_t addr;
    host_bridge_pkg::host_word_t data;
    host_bridge_pkg::host_word_t exp;
    host_bridge_pkg::host_word_t got;
    void'($urandom(32'h184e_5ea4));
    rstn         = 1'b0;
    host_en      = 1'b0;
    host_we      = 4'h0;
    host_addr    = '0;
    host_din     = '0;
    awready      = 1'b1;
    wready       = 1'b1;
    bvalid       = 1'b0;
    bid          = '0;
    bresp        = '0;
    random_ready = 1'b0;
    aw_hold      = 1'b0;
    w_hold       = 1'b0;
    errors       = 0;
    checks       = 0;
    foreach (stage_model[i]) stage_model[i] = '0;
    $readmemh("tb/test_input.txt", vec_mem);
    n = 0;
    while (n < MAX_VEC && vec_mem[4*n] !== OP_END) n++;
    num_vec = n;
    if (num_vec == 0) begin
      errors++;
      $display("no test vectors were loaded");
    end
    repeat (5) @(posedge clk);
    check(128'(ocu_rstn), 128'(0), "ocu_rstn during reset");
    check(128'(awvalid), 128'(0), "awvalid in reset");
    check(128'(wvalid), 128'(0), "wvalid in reset");
    check(128'(bready), 128'(1), "bready in reset");
    rstn <= 1'b1;
    for (int i = 0; i < num_vec; i++) begin
      op   = vec_mem[4*i];
      addr = vec_mem[4*i+1];
      data = vec_mem[4*i+2];
      exp  = vec_mem[4*i+3];
      case (op)
        OP_WRITE: host_write(host_bridge_pkg::host_addr_t'(addr), data);
        OP_READ: begin
          host_read(host_bridge_pkg::host_addr_t'(addr), got);
          check(128'(got), 128'(exp), $sformatf("read of 0x%0h", addr));
        end
        OP_B:    b_inject(data);
        OP_BEAT: expect_beat(host_bridge_pkg::host_addr_t'(addr), exp);
        OP_RAND: begin
          @(posedge clk);
          random_ready <= data[0];
        end
        OP_LINK: begin
          repeat (2) @(posedge clk);  // register stage plus output flop
          check(128'(ocu_rstn), 128'(exp[0]), "ocu_rstn level");
        end
        default: begin
          errors++;
          $display("vector %0d has an unknown opcode %0h", i, op);
        end
      endcase
    end
    repeat (10) @(posedge clk);
    check(128'(aw_got_q.size()), 128'(0), "AW handshakes left unchecked");
    check(128'(aw_exp_q.size()), 128'(0), "AW pushes that never came out");
    check(128'(w_got_q.size()), 128'(0), "W handshakes left unchecked");
    check(128'(w_exp_q.size()), 128'(0), "W pushes that never came out");
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/test_input.txt */
// opcode address data expected, all hex
// 0 write, 1 read, 2 B inject {id,resp}, 3 next AW (20) or W (30), 4 random ready, 5 ocu_rstn, f end
5 0 0 1
0 00 89abcdef 0
0 04 00000012 0
0 08 00000003 0
0 0c 0f1e2d3c 0
0 10 0000ffff 0
0 14 a5a5a5a5 0
0 18 5a5a5a5a 0
0 1c deadbeef 0
1 00 0 89abcdef
1 0c 0 0f1e2d3c
1 14 0 a5a5a5a5
1 1c 0 deadbeef
0 20 0 0
3 20 0 89abcdef
4 0 1 0
0 30 0 0
0 00 11110000 0
0 20 0 0
0 30 0 0
0 10 000000f0 0
0 30 0 0
0 20 0 0
3 20 0 11110000
3 20 0 11110000
3 30 0 89abcdef
3 30 0 11110000
3 30 0 11110000
4 0 0 0
1 50 0 0
2 0 6 0
1 50 0 1
0 54 0 0
1 00 0 6
1 04 0 0
1 1c 0 0
1 50 0 0
0 c0 0 0
5 0 0 0
0 c4 0 0
5 0 0 1
f 0 0 0
